// ==== Makefile ====
# Verilator build and run of the UART testbench.

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module tb_uart_hw -f sim.f \
		--Mdir $(OBJ_DIR) -o sim_uart

# The log decides the result, a missing pass line fails the target.
run: compile
	./$(OBJ_DIR)/sim_uart | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

// ==== logic/pi1_pkg.sv ====
/*
 * Peripheral bus definitions.
 * Bus operation encoding, address width helper and mapped size.
 */

`default_nettype none

package pi1_pkg;

	// Operation driven by the bus master each cycle.
	typedef enum logic [1:0] {
		PINOOP = 2'b00,
		PIWROP = 2'b01,
		PIRDOP = 2'b10,
		PIRWOP = 2'b11
	} pi1_op_e;

	// Word address width for a given data width.
	function automatic int addr_bits(int archbitsz);
		return archbitsz - $clog2(archbitsz / 8);
	endfunction

	// One word is mapped, padded up to a 64-bit boundary.
	function automatic int mapsz_bytes(int archbitsz);
		return ((archbitsz < 64) ? (64 / archbitsz) : 1) * (archbitsz / 8);
	endfunction

	// Padding makes the size equal for every supported width.
	localparam int MIN_ARCHBITSZ = 16;
	localparam int MAPSZ_BYTES = mapsz_bytes(MIN_ARCHBITSZ);

endpackage

`default_nettype wire

// ==== logic/uart_fifo.sv ====
/*
 * Byte FIFO with occupancy count.
 * Circular buffer, combinational read of the head entry.
 */

`default_nettype none

module uart_fifo #(
	parameter int DEPTH = 4
) (
	input  wire                      clk_i,
	input  wire                      rst_i,
	input  wire                      push_i,
	input  wire  [7:0]               push_data_i,
	input  wire                      pop_i,
	output logic [7:0]               pop_data_o,
	output logic                     empty_o,
	output logic [$clog2(DEPTH):0]   count_o
);

	localparam int AW = $clog2(DEPTH);

	logic [7:0]    mem [DEPTH];
	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;
	logic [AW:0]   count;

	// Pointers wrap naturally since DEPTH is a power of two.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (push_i)
				wptr <= wptr + 1'b1;
			if (pop_i)
				rptr <= rptr + 1'b1;
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (push_i)
			mem[wptr] <= push_data_i;
	end

	// Head entry is visible as soon as it is written.
	assign pop_data_o = mem[rptr];
	assign empty_o    = (count == '0);
	assign count_o    = count;

	// Senders hold credits, so the FIFO is never overrun or underrun.
	a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
		push_i |-> (count != (AW+1)'(DEPTH)))
		else $error("uart_fifo push while full");

	a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
		pop_i |-> !empty_o)
		else $error("uart_fifo pop while empty");

endmodule

`default_nettype wire

// ==== logic/uart_hw.sv ====
/*
 * UART peripheral top level.
 * Bus slave, transmitter and receiver on plain bus and serial ports.
 */

`default_nettype none

module uart_hw #(
	parameter int ARCHBITSZ = 32,
	parameter int BUFSZ = 4,
	parameter int CLKS_PER_BIT_RST = 8
) (
	input  wire                                      clk_i,
	input  wire                                      rst_i,
	input  wire  pi1_pkg::pi1_op_e                   pi1_op_i,
	input  wire  [pi1_pkg::addr_bits(ARCHBITSZ)-1:0] pi1_addr_i,
	input  wire  [ARCHBITSZ-1:0]                     pi1_data_i,
	output logic [ARCHBITSZ-1:0]                     pi1_data_o,
	input  wire  [ARCHBITSZ/8-1:0]                   pi1_sel_i,
	output logic                                     pi1_rdy_o,
	output logic [ARCHBITSZ-1:0]                     pi1_mapsz_o,
	output logic                                     intrqst_o,
	input  wire                                      intrdy_i,
	output logic                                     tx_o,
	input  wire                                      rx_i
);

	logic                           tx_vld;
	logic [7:0]                     tx_data;
	logic                           tx_crd;
	logic [uart_pkg::CPB_BITSZ-1:0] clks_per_bit;

	uart_rx_if rx_bus ();

	// Single mapped word, so address and byte selects are ignored.
	assign pi1_mapsz_o = ARCHBITSZ'(pi1_pkg::MAPSZ_BYTES);

	uart_regs #(
		.ARCHBITSZ        (ARCHBITSZ),
		.BUFSZ            (BUFSZ),
		.CLKS_PER_BIT_RST (CLKS_PER_BIT_RST)
	) i_uart_regs (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.pi1_op_i       (pi1_op_i),
		.pi1_data_i     (pi1_data_i),
		.pi1_data_o     (pi1_data_o),
		.pi1_rdy_o      (pi1_rdy_o),
		.intrqst_o      (intrqst_o),
		.intrdy_i       (intrdy_i),
		.tx_vld_o       (tx_vld),
		.tx_data_o      (tx_data),
		.tx_crd_i       (tx_crd),
		.clks_per_bit_o (clks_per_bit),
		.rx             (rx_bus.snk)
	);

	uart_tx #(.BUFSZ(BUFSZ)) i_uart_tx (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.tx_vld_i       (tx_vld),
		.tx_data_i      (tx_data),
		.tx_crd_o       (tx_crd),
		.clks_per_bit_i (clks_per_bit),
		.tx_o           (tx_o)
	);

	uart_rx #(.BUFSZ(BUFSZ)) i_uart_rx (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.rx_i           (rx_i),
		.clks_per_bit_i (clks_per_bit),
		.rx             (rx_bus.src)
	);

endmodule

`default_nettype wire

// ==== logic/uart_pkg.sv ====
/*
 * UART definitions.
 * Command encoding, serializer states and frame constants.
 */

`default_nettype none

package uart_pkg;

	// Command field in the two top bits of a read-write word.
	typedef enum logic [1:0] {
		CMD_GETBUFFERUSAGE = 2'd0,
		CMD_SETINTERRUPT   = 2'd1,
		CMD_SETSPEED       = 2'd2
	} uart_cmd_e;

	// Frame phase, shared by transmitter and receiver.
	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} ser_state_e;

	// 8N1: start, eight data bits, stop.
	localparam int FRAME_BITS = 10;
	localparam int DATA_BITS = FRAME_BITS - 2;

	// Width of the clocks-per-bit setting.
	localparam int CPB_BITSZ = 16;

endpackage

`default_nettype wire

// ==== logic/uart_regs.sv ====
/*
 * Bus slave of the UART.
 * Op and command decode, receive buffer, transmit credits,
 * speed register and interrupt request.
 */

`default_nettype none

module uart_regs #(
	parameter int ARCHBITSZ = 32,
	parameter int BUFSZ = 4,
	parameter int CLKS_PER_BIT_RST = 8
) (
	input  wire                            clk_i,
	input  wire                            rst_i,
	input  wire  pi1_pkg::pi1_op_e         pi1_op_i,
	input  wire  [ARCHBITSZ-1:0]           pi1_data_i,
	output logic [ARCHBITSZ-1:0]           pi1_data_o,
	output logic                           pi1_rdy_o,
	output logic                           intrqst_o,
	input  wire                            intrdy_i,
	output logic                           tx_vld_o,
	output logic [7:0]                     tx_data_o,
	input  wire                            tx_crd_i,
	output logic [uart_pkg::CPB_BITSZ-1:0] clks_per_bit_o,
	uart_rx_if.snk                         rx
);

	localparam int CNTW = $clog2(BUFSZ) + 1;
	localparam int ARGW = ARCHBITSZ - 2;
	localparam int CPBW = uart_pkg::CPB_BITSZ;

	logic [CNTW-1:0]      tx_crd_cnt;
	logic                 wr_acc;
	logic                 rd_acc;
	logic                 rw_acc;
	logic                 rd_pop;
	uart_pkg::uart_cmd_e  cmd;
	logic [ARGW-1:0]      cmd_arg;
	logic [CPBW-1:0]      cpb_arg;
	logic [ARGW-1:0]      thresh_r;
	logic [CPBW-1:0]      cpb_r;
	logic                 intrdy_q;
	logic                 intrdy_fall;
	logic                 rx_push;
	logic                 rx_empty;
	logic [7:0]           rx_pop_data;
	logic [CNTW-1:0]      rx_count;
	logic                 drop_pend;
	logic [ARCHBITSZ-1:0] rw_result;

	// Writes stall without a transmit slot.
	assign wr_acc    = (pi1_op_i == pi1_pkg::PIWROP) && (tx_crd_cnt != '0);
	assign rd_acc    = (pi1_op_i == pi1_pkg::PIRDOP);
	assign rw_acc    = (pi1_op_i == pi1_pkg::PIRWOP);
	assign pi1_rdy_o = (pi1_op_i != pi1_pkg::PIWROP) || (tx_crd_cnt != '0);
	assign rd_pop    = rd_acc && !rx_empty;

	// Command in the top two bits, argument below.
	assign cmd     = uart_pkg::uart_cmd_e'(pi1_data_i[ARCHBITSZ-1 -: 2]);
	assign cmd_arg = pi1_data_i[ARGW-1:0];
	assign cpb_arg = CPBW'(cmd_arg);

	always_comb begin
		case (cmd)
			uart_pkg::CMD_GETBUFFERUSAGE:
				rw_result = (cmd_arg == '0) ? ARCHBITSZ'(rx_count) : '0;
			uart_pkg::CMD_SETINTERRUPT:
				rw_result = ARCHBITSZ'(BUFSZ);
			uart_pkg::CMD_SETSPEED:
				rw_result = (cpb_arg != '0) ? ARCHBITSZ'(cpb_arg) : ARCHBITSZ'(cpb_r);
			default:
				rw_result = '0;
		endcase
	end

	// Result holds until the next read or read-write.
	always_ff @(posedge clk_i) begin
		if (rd_acc)
			pi1_data_o <= rx_empty ? '0 : ARCHBITSZ'(rx_pop_data);
		else if (rw_acc)
			pi1_data_o <= rw_result;
	end

	// Transmit path, one beat per accepted write.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			tx_vld_o   <= 1'b0;
			tx_crd_cnt <= CNTW'(BUFSZ);
		end else begin
			tx_vld_o <= wr_acc;
			case ({wr_acc, tx_crd_i})
				2'b10:   tx_crd_cnt <= tx_crd_cnt - 1'b1;
				2'b01:   tx_crd_cnt <= tx_crd_cnt + 1'b1;
				default: tx_crd_cnt <= tx_crd_cnt;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_acc)
			tx_data_o <= pi1_data_i[7:0];
	end

	// Speed and interrupt threshold.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cpb_r    <= CPBW'(CLKS_PER_BIT_RST);
			thresh_r <= '0;
			intrdy_q <= 1'b0;
		end else begin
			intrdy_q <= intrdy_i;
			if (rw_acc && cmd == uart_pkg::CMD_SETSPEED && cpb_arg != '0)
				cpb_r <= cpb_arg;
			// A new threshold wins over an acknowledge in the same cycle.
			if (rw_acc && cmd == uart_pkg::CMD_SETINTERRUPT)
				thresh_r <= cmd_arg;
			else if (intrdy_fall)
				thresh_r <= '0;
		end
	end

	assign intrdy_fall    = intrdy_q && !intrdy_i;
	assign clks_per_bit_o = cpb_r;
	assign intrqst_o      = (thresh_r != '0) && (ARGW'(rx_count) >= thresh_r);

	// Bytes with a bad stop bit are discarded.
	assign rx_push = rx.vld && !rx.frm_err;

	uart_fifo #(.DEPTH(BUFSZ)) i_rx_fifo (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.push_i      (rx_push),
		.push_data_i (rx.data),
		.pop_i       (rd_pop),
		.pop_data_o  (rx_pop_data),
		.empty_o     (rx_empty),
		.count_o     (rx_count)
	);

	// A discarded byte returns its credit once no pop claims the pulse.
	always_ff @(posedge clk_i) begin
		if (rst_i)
			drop_pend <= 1'b0;
		else
			drop_pend <= (drop_pend && rd_pop) || (rx.vld && rx.frm_err);
	end

	assign rx.crd = rd_pop || drop_pend;

	// The transmitter returns only slots that writes have used.
	a_tx_crd_bound: assert property (@(posedge clk_i) disable iff (rst_i)
		tx_crd_cnt <= CNTW'(BUFSZ))
		else $error("uart_regs transmit credits above BUFSZ");

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
/*
 * UART receiver.
 * Two-flop synchronizer, mid-bit 8N1 deserializer and credit counter.
 */

`default_nettype none

module uart_rx #(
	parameter int BUFSZ = 4
) (
	input  wire                            clk_i,
	input  wire                            rst_i,
	input  wire                            rx_i,
	input  wire  [uart_pkg::CPB_BITSZ-1:0] clks_per_bit_i,
	uart_rx_if.src                         rx
);

	localparam int CPBW = uart_pkg::CPB_BITSZ;
	localparam int CNTW = $clog2(BUFSZ) + 1;

	uart_pkg::ser_state_e state;
	logic            rx_meta;
	logic            rx_sync;
	logic            rx_prev;
	logic [CPBW-1:0] cnt;
	logic [CPBW-1:0] half_lim;
	logic [CPBW-1:0] full_lim;
	logic [2:0]      bit_idx;
	logic [7:0]      shreg;
	logic            vld_r;
	logic            frm_err_r;
	logic [CNTW-1:0] crd_cnt;

	// Line is asynchronous to clk_i.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// Half a bit to the middle of start, then a full bit per sample.
	assign half_lim = (clks_per_bit_i > CPBW'(1)) ?
		(clks_per_bit_i >> 1) - CPBW'(1) : '0;
	assign full_lim = clks_per_bit_i - CPBW'(1);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state   <= uart_pkg::IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			vld_r   <= 1'b0;
		end else begin
			vld_r <= 1'b0;
			cnt   <= cnt + CPBW'(1);
			case (state)
				uart_pkg::IDLE: begin
					cnt <= '0;
					// Falling edge marks a possible start bit.
					if (rx_prev && !rx_sync)
						state <= uart_pkg::START;
				end
				uart_pkg::START: if (cnt == half_lim) begin
					cnt     <= '0;
					bit_idx <= '0;
					// A glitch shorter than half a bit is ignored.
					state   <= rx_sync ? uart_pkg::IDLE : uart_pkg::DATA;
				end
				uart_pkg::DATA: if (cnt == full_lim) begin
					cnt     <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'(uart_pkg::DATA_BITS - 1))
						state <= uart_pkg::STOP;
				end
				default: if (cnt == full_lim) begin
					// Without a credit the byte is lost.
					state <= uart_pkg::IDLE;
					vld_r <= (crd_cnt != '0);
				end
			endcase
		end
	end

	// Byte and framing flag only matter while vld is high.
	always_ff @(posedge clk_i) begin
		if (state == uart_pkg::DATA && cnt == full_lim)
			shreg <= {rx_sync, shreg[7:1]};
		if (state == uart_pkg::STOP && cnt == full_lim)
			frm_err_r <= !rx_sync;
	end

	// Spent on each delivered byte, returned per freed slot.
	always_ff @(posedge clk_i) begin
		if (rst_i)
			crd_cnt <= CNTW'(BUFSZ);
		else begin
			case ({vld_r, rx.crd})
				2'b10:   crd_cnt <= crd_cnt - 1'b1;
				2'b01:   crd_cnt <= crd_cnt + 1'b1;
				default: crd_cnt <= crd_cnt;
			endcase
		end
	end

	assign rx.vld     = vld_r;
	assign rx.data    = shreg;
	assign rx.frm_err = frm_err_r;

	// The bus block may not return more slots than it owns.
	a_crd_bound: assert property (@(posedge clk_i) disable iff (rst_i)
		crd_cnt <= CNTW'(BUFSZ))
		else $error("uart_rx credit count above BUFSZ");

endmodule

`default_nettype wire

// ==== logic/uart_rx_if.sv ====
/*
 * Receive byte channel from deserializer to bus block.
 * Carries the byte, its framing flag and the credit return.
 */

`default_nettype none

interface uart_rx_if;

	// Byte beat, one cycle wide.
	logic       vld;
	logic [7:0] data;
	// Stop bit was sampled low.
	logic       frm_err;
	// One pulse per receive slot freed.
	logic       crd;

	modport src (output vld, output data, output frm_err, input crd);

	modport snk (input vld, input data, input frm_err, output crd);

endinterface

`default_nettype wire

// ==== logic/uart_tx.sv ====
/*
 * UART transmitter.
 * Byte FIFO feeding an 8N1 serializer, one credit returned per byte taken.
 */

`default_nettype none

module uart_tx #(
	parameter int BUFSZ = 4
) (
	input  wire                           clk_i,
	input  wire                           rst_i,
	input  wire                           tx_vld_i,
	input  wire  [7:0]                    tx_data_i,
	output logic                          tx_crd_o,
	input  wire  [uart_pkg::CPB_BITSZ-1:0] clks_per_bit_i,
	output logic                          tx_o
);

	localparam int CPBW = uart_pkg::CPB_BITSZ;

	uart_pkg::ser_state_e state;
	logic [CPBW-1:0] cnt;
	logic [2:0]      bit_idx;
	logic [7:0]      shreg;
	logic            tx_r;
	logic            fifo_empty;
	logic [7:0]      fifo_data;
	logic            take;
	logic            bit_end;

	uart_fifo #(.DEPTH(BUFSZ)) i_tx_fifo (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.push_i      (tx_vld_i),
		.push_data_i (tx_data_i),
		.pop_i       (take),
		.pop_data_o  (fifo_data),
		.empty_o     (fifo_empty),
		.count_o     ()
	);

	// Byte moves into the shifter from IDLE, freeing a slot.
	assign take     = (state == uart_pkg::IDLE) && !fifo_empty;
	assign tx_crd_o = take;
	// Last clock of the current bit time.
	assign bit_end  = (cnt == clks_per_bit_i - CPBW'(1));

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state   <= uart_pkg::IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			tx_r    <= 1'b1;
		end else begin
			cnt <= bit_end ? '0 : cnt + CPBW'(1);
			case (state)
				uart_pkg::IDLE: begin
					cnt <= '0;
					if (take) begin
						state <= uart_pkg::START;
						tx_r  <= 1'b0;
					end
				end
				uart_pkg::START: if (bit_end) begin
					state   <= uart_pkg::DATA;
					bit_idx <= '0;
					tx_r    <= shreg[0];
				end
				uart_pkg::DATA: if (bit_end) begin
					if (bit_idx == 3'(uart_pkg::DATA_BITS - 1)) begin
						state <= uart_pkg::STOP;
						tx_r  <= 1'b1;
					end else begin
						bit_idx <= bit_idx + 1'b1;
						tx_r    <= shreg[1];
					end
				end
				default: if (bit_end)
					state <= uart_pkg::IDLE;
			endcase
		end
	end

	// LSB first, shifted at each data bit boundary.
	always_ff @(posedge clk_i) begin
		if (take)
			shreg <= fifo_data;
		else if (state == uart_pkg::DATA && bit_end)
			shreg <= {1'b0, shreg[7:1]};
	end

	assign tx_o = tx_r;

	// Line must rest at mark level between frames.
	a_idle_high: assert property (@(posedge clk_i) disable iff (rst_i)
		(state == uart_pkg::IDLE) |-> tx_r)
		else $error("uart_tx line low while idle");

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verif
logic/pi1_pkg.sv
logic/uart_pkg.sv
logic/uart_rx_if.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_hw.sv
verif/tb_uart_hw.sv

// ==== verif/tb_uart_ref.svh ====
/*
 * Reference model for the UART testbench.
 * Xorshift byte source, expected receive buffer, command results,
 * interrupt level and the value comparison.
 */

`ifndef TB_UART_REF_SVH
`define TB_UART_REF_SVH

logic [31:0] rng_state = 32'd65200;
logic [7:0]  rx_model_q[$];
int          model_thresh;

// Xorshift32, low byte used as the next test byte.
function automatic logic [7:0] next_byte();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state[7:0];
endfunction

// A looped byte lands only while a buffer slot is free.
function automatic void model_send(input logic [7:0] b);
	if (rx_model_q.size() < BUFSZ)
		rx_model_q.push_back(b);
endfunction

// Reading an empty buffer gives zero.
function automatic logic [31:0] model_pop();
	if (rx_model_q.size() == 0)
		return 32'd0;
	return 32'(rx_model_q.pop_front());
endfunction

// Read-write result for each command.
function automatic logic [31:0] cmd_result(input uart_pkg::uart_cmd_e cmd,
		input logic [31:0] arg, input logic [31:0] usage, input logic [31:0] cpb);
	case (cmd)
		uart_pkg::CMD_GETBUFFERUSAGE: return (arg == 32'd0) ? usage : 32'd0;
		uart_pkg::CMD_SETINTERRUPT:   return 32'(BUFSZ);
		uart_pkg::CMD_SETSPEED:       return (arg != 32'd0) ? arg : cpb;
		default:                      return 32'd0;
	endcase
endfunction

// Request while a threshold is set and usage has reached it.
function automatic logic intr_level(input int thresh, input int usage);
	return (thresh != 0) && (usage >= thresh);
endfunction

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
		fail_now($sformatf("ERROR at time %0t: %s got 0x%0h expected 0x%0h",
			$time, name, got, exp));
endtask

`endif

// ==== verif/tb_uart_hw.sv ====
/*
 * Testbench for the UART peripheral.
 * Clock, reset, serial loopback, bus stimulus, comparison and watchdog.
 */

`default_nettype none

module tb_uart_hw;

	localparam int ARCHBITSZ = 32;
	localparam int BUFSZ = 4;
	localparam int CPB_RST = 8;
	localparam int CPB_SLOW = 16;
	localparam int N_LOOP = 6;
	localparam int N_BURST = 6;
	localparam int N_INTR = 2;
	localparam int FRAMES = 2 * N_LOOP + N_BURST + N_INTR;
	// Each frame is sent, then waited out once more as quiet line.
	localparam int WATCHDOG = FRAMES * 2 * uart_pkg::FRAME_BITS * CPB_SLOW * 10 + 20000;

	logic                                     clk;
	logic                                     rst;
	pi1_pkg::pi1_op_e                         pi1_op;
	logic [pi1_pkg::addr_bits(ARCHBITSZ)-1:0] pi1_addr;
	logic [ARCHBITSZ-1:0]                     pi1_data_in;
	logic [ARCHBITSZ-1:0]                     pi1_data_out;
	logic [ARCHBITSZ/8-1:0]                   pi1_sel;
	logic                                     pi1_rdy;
	logic [ARCHBITSZ-1:0]                     pi1_mapsz;
	logic                                     intrqst;
	logic                                     intrdy;
	wire                                      tx_line;

	int          cur_cpb;
	int          frames_seen;
	int          writes_done;
	bit          stall_seen;
	string       chk_name_q[$];
	logic [31:0] chk_got_q[$];
	logic [31:0] chk_exp_q[$];

	`include "tb_uart_ref.svh"

	// Serial output looped straight back into the receiver.
	uart_hw #(
		.ARCHBITSZ        (ARCHBITSZ),
		.BUFSZ            (BUFSZ),
		.CLKS_PER_BIT_RST (CPB_RST)
	) i_uart_hw (
		.clk_i       (clk),
		.rst_i       (rst),
		.pi1_op_i    (pi1_op),
		.pi1_addr_i  (pi1_addr),
		.pi1_data_i  (pi1_data_in),
		.pi1_data_o  (pi1_data_out),
		.pi1_sel_i   (pi1_sel),
		.pi1_rdy_o   (pi1_rdy),
		.pi1_mapsz_o (pi1_mapsz),
		.intrqst_o   (intrqst),
		.intrdy_i    (intrdy),
		.tx_o        (tx_line),
		.rx_i        (tx_line)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	// Compared later by the checking process.
	task automatic queue_check(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		chk_name_q.push_back(name);
		chk_got_q.push_back(got);
		chk_exp_q.push_back(exp);
	endtask

	// One op, held until accepted; rdy is stable at the falling edge.
	task automatic bus_op(input pi1_pkg::pi1_op_e op, input logic [31:0] wdata,
			output logic [31:0] rdata);
		pi1_op      = op;
		pi1_data_in = wdata;
		@(negedge clk);
		while (!pi1_rdy) begin
			stall_seen = 1'b1;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		pi1_op      = pi1_pkg::PINOOP;
		pi1_data_in = '0;
		rdata       = pi1_data_out;
	endtask

	task automatic write_byte(input logic [7:0] b);
		logic [31:0] unused;
		bus_op(pi1_pkg::PIWROP, 32'(b), unused);
		writes_done++;
		model_send(b);
	endtask

	task automatic read_check();
		logic [31:0] rdata;
		logic [31:0] exp;
		exp = model_pop();
		bus_op(pi1_pkg::PIRDOP, 32'd0, rdata);
		queue_check("pi1_data_o", rdata, exp);
	endtask

	// Command word: two command bits over a 30-bit argument.
	task automatic run_command(input uart_pkg::uart_cmd_e cmd, input int arg,
			input string name);
		logic [31:0] rdata;
		logic [31:0] exp;
		exp = cmd_result(cmd, 32'(arg), 32'(rx_model_q.size()), 32'(cur_cpb));
		bus_op(pi1_pkg::PIRWOP, {cmd, 30'(arg)}, rdata);
		queue_check(name, rdata, exp);
		if (cmd == uart_pkg::CMD_SETINTERRUPT)
			model_thresh = arg;
		if (cmd == uart_pkg::CMD_SETSPEED && arg != 0)
			cur_cpb = arg;
	endtask

	task automatic check_intr(input string name);
		queue_check(name, 32'(intrqst), 32'(intr_level(model_thresh, rx_model_q.size())));
	endtask

	// Line high for a whole frame means sending and receiving are done.
	task automatic wait_quiet();
		int quiet;
		int waited;
		quiet  = 0;
		waited = 0;
		while (quiet < uart_pkg::FRAME_BITS * cur_cpb + 8) begin
			@(negedge clk);
			quiet = tx_line ? quiet + 1 : 0;
			waited++;
			if (waited > (N_BURST + 2) * uart_pkg::FRAME_BITS * cur_cpb)
				fail_now("The serial line never went quiet after sending");
		end
		@(posedge clk);
		#1;
	endtask

	// Usage checked after every byte, buffer drained every third byte.
	task automatic loopback(input int n);
		for (int i = 0; i < n; i++) begin
			write_byte(next_byte());
			wait_quiet();
			run_command(uart_pkg::CMD_GETBUFFERUSAGE, 0, "usage");
			if (i % 3 == 2 || i == n - 1) begin
				while (rx_model_q.size() != 0)
					read_check();
			end
		end
	endtask

	// Counts start bits, skipping the rest of each frame.
	initial begin
		frames_seen = 0;
		forever begin
			@(negedge clk);
			if (!rst && tx_line === 1'b0) begin
				frames_seen++;
				repeat (uart_pkg::FRAME_BITS * cur_cpb - 1) @(negedge clk);
			end
		end
	end

	initial begin
		forever begin
			@(negedge clk);
			while (chk_got_q.size() != 0)
				check_eq(chk_name_q.pop_front(), chk_got_q.pop_front(), chk_exp_q.pop_front());
		end
	end

	initial begin
		#(WATCHDOG);
		fail_now("Timeout: the tests did not finish in the expected time");
	end

	initial begin
		rst          = 1'b1;
		pi1_op       = pi1_pkg::PINOOP;
		pi1_addr     = '0;
		pi1_data_in  = '0;
		pi1_sel      = '1;
		intrdy       = 1'b0;
		cur_cpb      = CPB_RST;
		writes_done  = 0;
		stall_seen   = 1'b0;
		model_thresh = 0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		queue_check("pi1_mapsz_o", pi1_mapsz, 32'(64 / 8));
		queue_check("pi1_rdy_o", 32'(pi1_rdy), 32'd1);
		queue_check("tx_o", 32'(tx_line), 32'd1);
		check_intr("intrqst_o");

		loopback(N_LOOP);

		// Burst past both buffers; extra bytes find no receive slot.
		stall_seen = 1'b0;
		repeat (N_BURST) write_byte(next_byte());
		queue_check("pi1_rdy_o dropped", 32'(stall_seen), 32'd1);
		wait_quiet();
		queue_check("tx frames", 32'(frames_seen), 32'(writes_done));
		run_command(uart_pkg::CMD_GETBUFFERUSAGE, 0, "usage after overrun");
		run_command(uart_pkg::CMD_GETBUFFERUSAGE, 1, "usage with argument");
		repeat (BUFSZ) read_check();
		read_check();

		run_command(uart_pkg::CMD_SETINTERRUPT, 0, "setinterrupt 0");
		check_intr("intrqst_o");

		run_command(uart_pkg::CMD_SETINTERRUPT, 2, "setinterrupt 2");
		repeat (N_INTR) write_byte(next_byte());
		wait_quiet();
		run_command(uart_pkg::CMD_GETBUFFERUSAGE, 0, "usage at threshold");
		check_intr("intrqst_o raised");
		// Acknowledge on the falling edge of intrdy.
		intrdy = 1'b1;
		@(posedge clk);
		#1;
		intrdy = 1'b0;
		@(posedge clk);
		#1;
		model_thresh = 0;
		check_intr("intrqst_o cleared");
		run_command(uart_pkg::CMD_GETBUFFERUSAGE, 0, "usage after ack");
		repeat (N_INTR) read_check();

		run_command(uart_pkg::CMD_SETSPEED, CPB_SLOW, "setspeed");
		loopback(N_LOOP);

		// Two falling edges let the checking process drain the queue.
		repeat (2) @(negedge clk);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire
